// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_dma_ctrl
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := *** FAILED ***
PASS_MSG  := *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation ended without a result line"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim.f
src/dma_ctrl_pkg.sv
src/tlb_entry_assembler.sv
src/axil_write_engine.sv
src/stat_reg_mux.sv
src/axil_read_engine.sv
src/dma_ctrl_top.sv
sim/tb_clock_gen.sv
sim/dma_ctrl_asserts.sv
sim/tb_dma_ctrl.sv

// File: sim/dma_ctrl_asserts.sv
// ====================
// protocol checks on the dma control block ports
// ====================
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_asserts (
  input logic                                user_clk,
  input logic                                user_aresetn,
  input dma_ctrl_pkg::axil_b_t               b,
  input logic                                b_valid,
  input logic                                b_ready,
  input logic                                r_valid,
  input logic                                r_ready,
  input logic [dma_ctrl_pkg::tlb_data_w-1:0] tlb_data,
  input logic                                tlb_valid,
  input logic                                tlb_ready,
  input logic                                reset_write_len,
  input logic                                reset_read_len
);

  // responses hold until taken
  b_hold: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else $error("b_valid dropped or b changed before its transfer");

  r_hold: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    r_valid && !r_ready |=> r_valid)
    else $error("r_valid dropped before its transfer");

  tlb_hold: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    tlb_valid && !tlb_ready |=> tlb_valid && $stable(tlb_data))
    else $error("tlb_valid dropped or tlb_data changed before its transfer");

  // last tlb word answers only after the entry has left
  tlb_b_excl: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    !(tlb_valid && b_valid))
    else $error("tlb_valid and b_valid high together");

  wr_len_pulse: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    reset_write_len |=> !reset_write_len)
    else $error("reset_write_len longer than one cycle");

  rd_len_pulse: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    reset_read_len |=> !reset_read_len)
    else $error("reset_read_len longer than one cycle");

endmodule

bind dma_ctrl_top dma_ctrl_asserts u_asserts (
  .user_clk, .user_aresetn,
  .b, .b_valid, .b_ready,
  .r_valid, .r_ready,
  .tlb_data, .tlb_valid, .tlb_ready,
  .reset_write_len, .reset_read_len
);

`default_nettype wire

// File: sim/tb_clock_gen.sv
// ====================
// testbench clock and reset source
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic user_clk,
  output logic user_aresetn
);
  localparam int half_period  = 50; // 100 ns clock
  localparam int reset_cycles = 3;

  initial begin
    user_clk = 1'b0;
    forever #half_period user_clk = ~user_clk;
  end

  initial begin
    user_aresetn = 1'b0;
    repeat (reset_cycles) @(posedge user_clk);
    @(negedge user_clk);
    user_aresetn = 1'b1; // release away from the active edge
  end

endmodule

`default_nettype wire

// File: sim/tb_dma_ctrl.sv
// ====================
// testbench for the dma control block: tlb writes, length and debug reads
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_dma_ctrl;
  import dma_ctrl_pkg::*;

  localparam int          ops_per_round = 37; // 5 tlb, 2 clears, 22 reads, 5 bad reads, 3 bad writes
  localparam int          num_rounds    = 3;
  localparam int          cycles_per_op = 200;
  localparam logic [15:0] lfsr_seed     = 16'd20570;
  localparam logic [15:0] lfsr_taps     = 16'hb400; // x^16+x^14+x^13+x^11+1

  logic                  user_clk;
  logic                  user_aresetn;
  axil_aw_t              aw;
  logic                  aw_valid;
  logic                  aw_ready;
  axil_w_t               w;
  logic                  w_valid;
  logic                  w_ready;
  axil_b_t               b;
  logic                  b_valid;
  logic                  b_ready;
  axil_ar_t              ar;
  logic                  ar_valid;
  logic                  ar_ready;
  axil_r_t               r;
  logic                  r_valid;
  logic                  r_ready;
  logic [tlb_data_w-1:0] tlb_data;
  logic                  tlb_valid;
  logic                  tlb_ready;
  dma_stats_t            stats;
  logic                  reset_write_len;
  logic                  reset_read_len;

  // scoreboard
  axil_r_t               exp_r[$];
  int                    exp_b[$];   // tlb beats that must precede each b
  logic [tlb_data_w-1:0] exp_tlb[$];
  axil_r_t               r_exp;
  logic [tlb_data_w-1:0] tlb_exp;
  int                    b_need;
  int errors        = 0;
  int checks        = 0;
  int tlb_seen      = 0;
  int wr_pulses     = 0;
  int rd_pulses     = 0;
  int exp_wr_pulses = 0;
  int exp_rd_pulses = 0;
  int entries_done  = 0;

  // stimulus and model state
  logic [15:0] lfsr;
  bit          random_bp = 1'b0;
  int          tlb_stall = 0; // ticks left with tlb_ready forced low
  bit          wr_hi     = 1'b0;
  bit          rd_hi     = 1'b0;
  int          dbg_ptr   = 0;

  tb_clock_gen u_clk (.user_clk, .user_aresetn);

  dma_ctrl_top dut (.*);

  task automatic value_error(input string msg);
    errors++;
    $display("[FAIL] t=%0d ns: %s", $time, msg);
  endtask

  task automatic protocol_error(input string msg);
    errors++;
    $display("error at %0d ns: %s", $time, msg);
  endtask

  // galois step, one output bit per call
  function automatic logic lfsr_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ lfsr_taps;
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // expected r beat from the register map rules
  function automatic axil_r_t expected_read(input logic [reg_index_w-1:0] idx,
                                            input dma_stats_t s, input bit wr_upper,
                                            input bit rd_upper, input int ptr);
    axil_r_t     e;
    logic [47:0] len;
    e.resp = resp_okay;
    e.data = '0;
    case (idx)
      reg_dma_reads: begin
        len = s.read_len_cnt;
        if (s.reads_flushed) e.data = rd_upper ? {16'h0, len[47:32]} : len[31:0];
      end
      reg_dma_writes: begin
        len    = s.write_len_cnt;
        e.data = wr_upper ? {16'h0, len[47:32]} : len[31:0];
      end
      reg_debug: begin
        case (ptr)
          0: e.data = s.write_cmd_cnt;
          1: e.data = s.write_word_cnt;
          2: e.data = s.write_pkg_cnt;
          3: e.data = s.write_len_cnt[31:0];
          4: e.data = s.read_cmd_cnt;
          5: e.data = s.read_word_cnt;
          6: e.data = s.read_pkg_cnt;
          7: e.data = s.read_len_cnt[31:0];
          8: e.data = s.tlb_miss_cnt;
          default: e.data = s.tlb_page_cross_cnt;
        endcase
      end
      default: begin
        e.resp = resp_slverr;
        e.data = 32'hdeadbeef;
      end
    endcase
    return e;
  endfunction

  // words 0..3 in order, flag bit of word 4 at 128, padding zero
  function automatic logic [tlb_data_w-1:0] expected_tlb(
    input logic [tlb_words-1:0][axil_data_w-1:0] wd
  );
    return {7'h0, wd[4][0], wd[3], wd[2], wd[1], wd[0]};
  endfunction

  task automatic randomize_stats(input bit flushed);
    logic [31:0] hi;
    stats.write_cmd_cnt      = rand_bits(32);
    stats.write_word_cnt     = rand_bits(32);
    stats.write_pkg_cnt      = rand_bits(32);
    stats.read_cmd_cnt       = rand_bits(32);
    stats.read_word_cnt      = rand_bits(32);
    stats.read_pkg_cnt       = rand_bits(32);
    hi                       = rand_bits(16);
    stats.write_len_cnt      = {hi[15:0], rand_bits(32)};
    hi                       = rand_bits(16);
    stats.read_len_cnt       = {hi[15:0], rand_bits(32)};
    stats.tlb_miss_cnt       = rand_bits(32);
    stats.tlb_page_cross_cnt = rand_bits(32);
    stats.reads_flushed      = flushed;
  endtask

  // one falling edge, new ready values for the host and tlb consumer
  task automatic tick();
    @(negedge user_clk);
    if (random_bp) begin
      b_ready   = lfsr_bit();
      r_ready   = lfsr_bit();
      tlb_ready = lfsr_bit();
    end else begin
      b_ready   = 1'b1;
      r_ready   = 1'b1;
      tlb_ready = 1'b1;
    end
    if (tlb_stall > 0) begin
      tlb_ready = 1'b0;
      tlb_stall--;
    end
  endtask

  task automatic write_reg(input logic [reg_index_w-1:0] idx, input logic [31:0] data,
                           input int tlb_need);
    exp_b.push_back(tlb_need);
    aw.addr  = {20'h0, idx, 5'h0};
    aw_valid = 1'b1;
    while (!aw_ready) tick(); // ready seen here is the one the next edge uses
    tick();
    aw_valid = 1'b0;
    w.data   = data;
    w.strb   = 4'hf;
    w_valid  = 1'b1;
    while (!w_ready) tick();
    tick();
    w_valid = 1'b0;
    while (!(b_valid && b_ready)) tick();
    tick();
    checks++;
    assert (wr_pulses == exp_wr_pulses && rd_pulses == exp_rd_pulses)
      else value_error($sformatf("clear pulses wr %0d rd %0d, expected wr %0d rd %0d",
                                 wr_pulses, rd_pulses, exp_wr_pulses, exp_rd_pulses));
  endtask

  task automatic read_reg(input logic [reg_index_w-1:0] idx);
    exp_r.push_back(expected_read(idx, stats, wr_hi, rd_hi, dbg_ptr));
    if (idx == reg_dma_reads) rd_hi = !rd_hi; // flips even when masked
    else if (idx == reg_dma_writes) wr_hi = !wr_hi;
    else if (idx == reg_debug) dbg_ptr = (dbg_ptr + 1) % num_debug_regs;
    ar.addr  = {20'h0, idx, 5'h0};
    ar_valid = 1'b1;
    while (!ar_ready) tick();
    tick();
    ar_valid = 1'b0;
    while (!(r_valid && r_ready)) tick();
    tick();
  endtask

  task automatic run_round(input bit bp);
    logic [tlb_words-1:0][axil_data_w-1:0] words;
    random_bp = bp;
    for (int i = 0; i < tlb_words; i++) begin
      words[i] = rand_bits(32);
    end
    exp_tlb.push_back(expected_tlb(words));
    for (int i = 0; i < tlb_words; i++) begin
      if (i == tlb_words - 1) tlb_stall = 30; // consumer stalls the finished entry
      write_reg(reg_tlb, words[i], (i == tlb_words - 1) ? entries_done + 1 : entries_done);
    end
    entries_done++;
    exp_wr_pulses++;
    write_reg(reg_dma_writes, rand_bits(32), entries_done);
    exp_rd_pulses++;
    write_reg(reg_dma_reads, rand_bits(32), entries_done);
    randomize_stats(1'b1);
    repeat (4) read_reg(reg_dma_writes);
    repeat (4) read_reg(reg_dma_reads);
    stats.reads_flushed = 1'b0; // read length now masked
    repeat (3) read_reg(reg_dma_reads); // odd count leaves the toggle on the upper half
    randomize_stats(1'b1);
    repeat (num_debug_regs + 1) read_reg(reg_debug);
    read_reg(7'd0);
    read_reg(reg_tlb);  // write only
    read_reg(7'd5);
    read_reg(7'd12);
    read_reg(7'd127);
    write_reg(7'd0, rand_bits(32), entries_done);
    write_reg(7'd5, rand_bits(32), entries_done);
    write_reg(7'd127, rand_bits(32), entries_done);
  endtask

  // compare every transfer as the clock edge takes it
  always @(posedge user_clk) begin
    if (user_aresetn) begin
      if (reset_write_len) wr_pulses++;
      if (reset_read_len) rd_pulses++;
      if (tlb_valid && tlb_ready) begin
        tlb_seen++;
        if (exp_tlb.size() == 0) begin
          protocol_error("tlb entry sent with none expected");
        end else begin
          tlb_exp = exp_tlb.pop_front();
          checks++;
          assert (tlb_data == tlb_exp)
            else value_error($sformatf("tlb got %h expected %h", tlb_data, tlb_exp));
        end
      end
      if (b_valid && b_ready) begin
        if (exp_b.size() == 0) begin
          protocol_error("write response with no write outstanding");
        end else begin
          b_need = exp_b.pop_front();
          checks++;
          assert (b.resp == resp_okay && tlb_seen == b_need)
            else value_error($sformatf("b resp %0d after %0d tlb beats, expected 0 after %0d",
                                       b.resp, tlb_seen, b_need));
        end
      end
      if (r_valid && r_ready) begin
        if (exp_r.size() == 0) begin
          protocol_error("read data with no read outstanding");
        end else begin
          r_exp = exp_r.pop_front();
          checks++;
          assert (r == r_exp)
            else value_error($sformatf("r got %h resp %0d expected %h resp %0d",
                                       r.data, r.resp, r_exp.data, r_exp.resp));
        end
      end
    end
  end

  initial begin
    lfsr      = lfsr_seed;
    aw        = '0;
    aw_valid  = 1'b0;
    w         = '0;
    w_valid   = 1'b0;
    b_ready   = 1'b0;
    ar        = '0;
    ar_valid  = 1'b0;
    r_ready   = 1'b0;
    tlb_ready = 1'b0;
    stats     = '0;
    wait (user_aresetn === 1'b1);
    tick();
    run_round(1'b0); // full ready, long tlb stall
    run_round(1'b1); // random back-pressure
    run_round(1'b1);
    repeat (5) tick();
    assert (exp_b.size() == 0 && exp_r.size() == 0 && exp_tlb.size() == 0)
      else protocol_error("some expected transfers never happened");
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog, budget scales with the number of bus operations
  initial begin
    repeat (num_rounds * ops_per_round * cycles_per_op) @(posedge user_clk);
    $display("timeout: test did not finish within %0d cycles",
             num_rounds * ops_per_round * cycles_per_op);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/axil_read_engine.sv
// ====================
// axi-lite read engine: latches the read index, returns one r beat per ar
// ====================
`timescale 1ns/1ps
`default_nettype none

module axil_read_engine (
  input  logic                     user_clk,
  input  logic                     user_aresetn,
  input  dma_ctrl_pkg::axil_ar_t   ar,
  input  logic                     ar_valid,
  output logic                     ar_ready,
  output dma_ctrl_pkg::axil_r_t    r,
  output logic                     r_valid,
  input  logic                     r_ready,
  output dma_ctrl_pkg::reg_index_e rd_index,
  output logic                     rd_done,
  input  dma_ctrl_pkg::axil_r_t    rd_payload
);
  import dma_ctrl_pkg::*;

  read_state_e state;
  logic        ar_fire;

  assign ar_fire = ar_valid && ar_ready;
  assign rd_done = r_valid && r_ready; // one cycle, on the r transfer
  assign r       = rd_payload;         // live stats while r_valid waits

  // index register, payload only
  always_ff @(posedge user_clk) begin
    if (ar_fire) begin
      rd_index <= reg_index_e'(ar.addr[reg_index_lsb +: reg_index_w]);
    end
  end

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      state    <= rd_idle;
      ar_ready <= 1'b0;
      r_valid  <= 1'b0;
    end else begin
      case (state)
        rd_idle: begin
          ar_ready <= 1'b1;
          if (ar_fire) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b1;
            state    <= rd_resp;
          end
        end
        rd_resp: begin
          if (rd_done) begin
            r_valid  <= 1'b0;
            ar_ready <= 1'b1; // accept the next read next cycle
            state    <= rd_idle;
          end
        end
        default: state <= rd_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/axil_write_engine.sv
// ====================
// axi-lite write engine: address decode, tlb word strobes and counter clears
// ====================
`timescale 1ns/1ps
`default_nettype none

module axil_write_engine (
  input  logic                                 user_clk,
  input  logic                                 user_aresetn,
  input  dma_ctrl_pkg::axil_aw_t               aw,
  input  logic                                 aw_valid,
  output logic                                 aw_ready,
  input  dma_ctrl_pkg::axil_w_t                w,
  input  logic                                 w_valid,
  output logic                                 w_ready,
  output dma_ctrl_pkg::axil_b_t                b,
  output logic                                 b_valid,
  input  logic                                 b_ready,
  output logic                                 tlb_word_we,
  output logic [dma_ctrl_pkg::axil_data_w-1:0] tlb_wdata,
  input  logic                                 tlb_busy,
  output logic                                 reset_write_len,
  output logic                                 reset_read_len
);
  import dma_ctrl_pkg::*;

  write_state_e state;
  reg_index_e   wr_index; // latched on the aw transfer
  logic         aw_fire;
  logic         w_fire;

  assign aw_fire = aw_valid && aw_ready;
  assign w_fire  = (state == wr_data) && w_valid && w_ready;

  // word goes to the assembler in the same cycle as the w transfer
  assign tlb_word_we = w_fire && (wr_index == reg_tlb);
  assign tlb_wdata   = w.data;

  // every write is accepted, unknown ones are simply dropped
  assign b = '{resp: resp_okay};

  always_ff @(posedge user_clk) begin
    if (aw_fire) begin
      wr_index <= reg_index_e'(aw.addr[reg_index_lsb +: reg_index_w]);
    end
  end

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      state           <= wr_idle;
      aw_ready        <= 1'b0;
      w_ready         <= 1'b0;
      b_valid         <= 1'b0;
      reset_write_len <= 1'b0;
      reset_read_len  <= 1'b0;
    end else begin
      // clear pulses last a single cycle
      reset_write_len <= 1'b0;
      reset_read_len  <= 1'b0;
      case (state)
        wr_idle: begin
          aw_ready <= 1'b1; // first cycle out of reset
          if (aw_fire) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b1;
            state    <= wr_data;
          end
        end
        wr_data: begin
          if (w_fire) begin
            w_ready <= 1'b0;
            case (wr_index)
              reg_tlb: begin
                state <= wr_tlb_wait; // response waits on the assembler
              end
              reg_dma_writes: begin
                reset_write_len <= 1'b1;
                b_valid         <= 1'b1;
                state           <= wr_resp;
              end
              reg_dma_reads: begin
                reset_read_len <= 1'b1;
                b_valid        <= 1'b1;
                state          <= wr_resp;
              end
              default: begin
                b_valid <= 1'b1; // unmapped, no side effect
                state   <= wr_resp;
              end
            endcase
          end
        end
        wr_tlb_wait: begin
          if (!tlb_busy) begin
            b_valid <= 1'b1;
            state   <= wr_resp;
          end
        end
        wr_resp: begin
          if (b_valid && b_ready) begin
            b_valid  <= 1'b0;
            aw_ready <= 1'b1; // ready for the next address right away
            state    <= wr_idle;
          end
        end
        default: state <= wr_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/dma_ctrl_pkg.sv
// ====================
// dma control registers: shared widths, register map, channel structs
// ====================
`default_nettype none

package dma_ctrl_pkg;

  // axi-lite bus geometry
  localparam int axil_addr_w = 32;
  localparam int axil_data_w = 32;

  // register index is addr[11:5], so registers sit 32 bytes apart
  localparam int reg_index_w   = 7;
  localparam int reg_index_lsb = 5;

  // tlb entry layout
  localparam int tlb_words   = 5;   // four full words plus one flag word
  localparam int tlb_data_w  = 136; // stream width, byte aligned
  localparam int tlb_entry_w = 129; // meaningful bits

  localparam int len_counter_w  = 48;
  localparam int num_debug_regs = 10;

  localparam logic [axil_data_w-1:0] bad_addr_data = 32'hdeadbeef;

  // register map, decoded like opcodes
  typedef enum logic [reg_index_w-1:0] {
    reg_tlb        = 7'd2,
    reg_dma_reads  = 7'd10, // read length counter, write clears it
    reg_dma_writes = 7'd11, // write length counter, write clears it
    reg_debug      = 7'd13  // auto-advancing counter window
  } reg_index_e;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axil_resp_e;

  // debug window order, pointer steps on every debug read
  typedef enum logic [3:0] {
    write_cmd,
    write_word,
    write_pkg,
    write_len,      // low 32 bits only
    read_cmd,
    read_word,
    read_pkg,
    read_len,       // low 32 bits only
    tlb_miss,
    tlb_page_cross
  } debug_sel_e;

  // request channels, valid travels beside the struct
  typedef struct packed {
    logic [axil_addr_w-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [axil_data_w-1:0]   data;
    logic [axil_data_w/8-1:0] strb; // not honoured, full-word writes
  } axil_w_t;

  typedef struct packed {
    logic [axil_addr_w-1:0] addr;
  } axil_ar_t;

  // response channels
  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

  typedef struct packed {
    logic [axil_data_w-1:0] data;
    axil_resp_e             resp;
  } axil_r_t;

  // counters from the dma and tlb blocks, all on user_clk
  typedef struct packed {
    logic [31:0]              write_cmd_cnt;
    logic [31:0]              write_word_cnt;
    logic [31:0]              write_pkg_cnt;
    logic [31:0]              read_cmd_cnt;
    logic [31:0]              read_word_cnt;
    logic [31:0]              read_pkg_cnt;
    logic [len_counter_w-1:0] write_len_cnt;
    logic [len_counter_w-1:0] read_len_cnt;
    logic [31:0]              tlb_miss_cnt;
    logic [31:0]              tlb_page_cross_cnt;
    logic                     reads_flushed; // read length valid only once set
  } dma_stats_t;

  typedef enum logic [1:0] {
    wr_idle,
    wr_data,
    wr_tlb_wait, // hold b until the tlb stream is free
    wr_resp
  } write_state_e;

  typedef enum logic {
    rd_idle,
    rd_resp
  } read_state_e;

endpackage

`default_nettype wire

// File: src/dma_ctrl_top.sv
// ====================
// dma control register block, axi-lite slave on user_clk
// ====================
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_top (
  input  logic                                user_clk,
  input  logic                                user_aresetn,
  input  dma_ctrl_pkg::axil_aw_t              aw,
  input  logic                                aw_valid,
  output logic                                aw_ready,
  input  dma_ctrl_pkg::axil_w_t               w,
  input  logic                                w_valid,
  output logic                                w_ready,
  output dma_ctrl_pkg::axil_b_t               b,
  output logic                                b_valid,
  input  logic                                b_ready,
  input  dma_ctrl_pkg::axil_ar_t              ar,
  input  logic                                ar_valid,
  output logic                                ar_ready,
  output dma_ctrl_pkg::axil_r_t               r,
  output logic                                r_valid,
  input  logic                                r_ready,
  output logic [dma_ctrl_pkg::tlb_data_w-1:0] tlb_data,
  output logic                                tlb_valid,
  input  logic                                tlb_ready,
  input  dma_ctrl_pkg::dma_stats_t            stats,
  output logic                                reset_write_len,
  output logic                                reset_read_len
);
  import dma_ctrl_pkg::*;

  // write side to assembler
  logic                   tlb_word_we;
  logic [axil_data_w-1:0] tlb_wdata;
  logic                   tlb_busy;

  // read side to mux
  reg_index_e rd_index;
  logic       rd_done;
  axil_r_t    rd_payload;

  axil_write_engine u_write (
    .user_clk, .user_aresetn,
    .aw, .aw_valid, .aw_ready,
    .w, .w_valid, .w_ready,
    .b, .b_valid, .b_ready,
    .tlb_word_we, .tlb_wdata, .tlb_busy,
    .reset_write_len, .reset_read_len
  );

  tlb_entry_assembler u_tlb (
    .user_clk, .user_aresetn,
    .tlb_word_we,
    .wdata (tlb_wdata),
    .tlb_data, .tlb_valid, .tlb_ready, .tlb_busy
  );

  axil_read_engine u_read (
    .user_clk, .user_aresetn,
    .ar, .ar_valid, .ar_ready,
    .r, .r_valid, .r_ready,
    .rd_index, .rd_done, .rd_payload
  );

  stat_reg_mux u_mux (
    .user_clk, .user_aresetn,
    .rd_index, .rd_done,
    .stats,
    .rd_payload
  );

endmodule

`default_nettype wire

// File: src/stat_reg_mux.sv
// ====================
// stats read mux: length halves, debug window and bad-address response
// ====================
`timescale 1ns/1ps
`default_nettype none

module stat_reg_mux (
  input  logic                     user_clk,
  input  logic                     user_aresetn,
  input  dma_ctrl_pkg::reg_index_e rd_index,
  input  logic                     rd_done,
  input  dma_ctrl_pkg::dma_stats_t stats,
  output dma_ctrl_pkg::axil_r_t    rd_payload
);
  import dma_ctrl_pkg::*;

  debug_sel_e dbg_ptr;
  logic       rd_len_upper; // next reg_dma_reads returns bits 47:32
  logic       wr_len_upper; // same for reg_dma_writes

  // low word, or the upper 16 bits zero extended
  function automatic logic [axil_data_w-1:0] len_half(
    input logic [len_counter_w-1:0] cnt,
    input logic                     upper
  );
    logic [axil_data_w-1:0] res;
    if (upper) begin
      res = {{(2*axil_data_w - len_counter_w){1'b0}}, cnt[len_counter_w-1:axil_data_w]};
    end else begin
      res = cnt[axil_data_w-1:0];
    end
    return res;
  endfunction

  always_comb begin
    rd_payload.resp = resp_okay;
    rd_payload.data = '0;
    case (rd_index)
      reg_dma_reads: begin
        // counter is meaningless until the read path has drained
        if (stats.reads_flushed) begin
          rd_payload.data = len_half(stats.read_len_cnt, rd_len_upper);
        end
      end
      reg_dma_writes: rd_payload.data = len_half(stats.write_len_cnt, wr_len_upper);
      reg_debug: begin
        case (dbg_ptr)
          write_cmd:      rd_payload.data = stats.write_cmd_cnt;
          write_word:     rd_payload.data = stats.write_word_cnt;
          write_pkg:      rd_payload.data = stats.write_pkg_cnt;
          write_len:      rd_payload.data = stats.write_len_cnt[axil_data_w-1:0];
          read_cmd:       rd_payload.data = stats.read_cmd_cnt;
          read_word:      rd_payload.data = stats.read_word_cnt;
          read_pkg:       rd_payload.data = stats.read_pkg_cnt;
          read_len:       rd_payload.data = stats.read_len_cnt[axil_data_w-1:0];
          tlb_miss:       rd_payload.data = stats.tlb_miss_cnt;
          tlb_page_cross: rd_payload.data = stats.tlb_page_cross_cnt;
          default:        rd_payload.resp = resp_slverr; // pointer never gets here
        endcase
      end
      default: begin
        rd_payload.resp = resp_slverr;
        rd_payload.data = bad_addr_data;
      end
    endcase
  end

  // read side effects, applied once per completed r beat
  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      dbg_ptr      <= write_cmd;
      rd_len_upper <= 1'b0;
      wr_len_upper <= 1'b0;
    end else if (rd_done) begin
      case (rd_index)
        reg_dma_reads:  rd_len_upper <= ~rd_len_upper; // flips even when masked
        reg_dma_writes: wr_len_upper <= ~wr_len_upper;
        reg_debug: begin
          if (dbg_ptr == debug_sel_e'(num_debug_regs - 1)) begin
            dbg_ptr <= write_cmd; // wrap
          end else begin
            dbg_ptr <= debug_sel_e'(dbg_ptr + 1'b1);
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/tlb_entry_assembler.sv
// ====================
// tlb entry assembler: packs five host words into one tlb stream beat
// ====================
`timescale 1ns/1ps
`default_nettype none

module tlb_entry_assembler (
  input  logic                                 user_clk,
  input  logic                                 user_aresetn,
  input  logic                                 tlb_word_we,
  input  logic [dma_ctrl_pkg::axil_data_w-1:0] wdata,
  output logic [dma_ctrl_pkg::tlb_data_w-1:0]  tlb_data,
  output logic                                 tlb_valid,
  input  logic                                 tlb_ready,
  output logic                                 tlb_busy
);
  import dma_ctrl_pkg::*;

  localparam int cnt_w = $clog2(tlb_words);

  logic [cnt_w-1:0]       word_cnt; // next word slot
  logic [tlb_entry_w-1:0] entry;
  logic                   tlb_fire;

  assign tlb_fire = tlb_valid && tlb_ready;

  // entry leaving this cycle no longer blocks the write response
  assign tlb_busy = tlb_valid && !tlb_ready;

  // top bits of the beat are padding
  assign tlb_data = {{(tlb_data_w - tlb_entry_w){1'b0}}, entry};

  // entry payload, no reset needed
  always_ff @(posedge user_clk) begin
    if (tlb_word_we) begin
      if (word_cnt == cnt_w'(tlb_words - 1)) begin
        entry[tlb_entry_w-1] <= wdata[0]; // last word carries a single flag bit
      end else begin
        entry[word_cnt*axil_data_w +: axil_data_w] <= wdata;
      end
    end
  end

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      word_cnt  <= '0;
      tlb_valid <= 1'b0;
    end else begin
      if (tlb_word_we) begin
        if (word_cnt == cnt_w'(tlb_words - 1)) begin
          tlb_valid <= 1'b1; // entry complete, offer it
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end
      if (tlb_fire) begin
        tlb_valid <= 1'b0;
        word_cnt  <= '0; // start the next entry
      end
    end
  end

endmodule

`default_nettype wire
